// File: testbench/io_trace.txt
# tip ring cn8 cmd_ptt strobes(rxclipn rxclipp run_sync this_mac) rqst addr data hold
# then expected keys(cw ptt inh) pa(inttr exttr envpa envop envbias rfsw) led ack, hex
# idle after reset
1 1 1 0 0 0 00 00000000 4 0 00 0 0
# command register, foreign address ignored
1 1 1 0 0 1 01 008C0000 4 0 00 0 0
1 1 1 0 0 1 09 00080000 4 0 01 0 1
1 1 1 0 0 1 09 00000000 4 0 00 0 1
# debounce, short pulse dropped
0 1 1 0 0 0 00 00000000 3 0 00 0 0
1 1 1 0 0 0 00 00000000 20 0 00 0 0
0 1 1 0 0 0 00 00000000 20 4 34 0 0
1 1 1 0 0 0 00 00000000 20 0 00 0 0
# effective ptt sources
1 1 1 1 0 0 00 00000000 3 0 34 0 0
1 1 1 0 0 0 00 00000000 3 0 00 0 0
1 0 1 0 0 0 00 00000000 20 2 34 0 0
0 0 1 1 0 0 00 00000000 20 6 34 0 0
0 0 0 1 0 0 00 00000000 20 7 00 0 0
1 1 1 0 0 0 00 00000000 20 0 00 0 0
# pa outputs with ptt on
1 1 1 1 0 1 09 00000000 4 0 34 0 1
1 1 1 1 0 1 09 00040000 4 0 14 0 1
1 1 1 1 0 1 09 00080000 4 0 3F 0 1
1 1 1 1 0 1 09 000C0000 4 0 3F 0 1
# vna with ptt off, then inhibit
1 1 1 0 0 1 09 00800000 4 0 04 0 1
1 1 0 0 0 0 00 00000000 20 1 00 0 0
1 1 1 0 0 0 00 00000000 20 0 04 0 0
1 1 1 0 0 1 09 00000000 4 0 00 0 1
# led stretching
1 1 1 0 4 0 00 00000000 8 0 00 4 0
1 1 1 0 0 0 00 00000000 20 0 00 0 0
1 1 1 0 1 0 00 00000000 1 0 00 1 0
1 1 1 0 0 0 00 00000000 20 0 00 0 0

// File: compile.f
source/io_pkg.sv
source/key_debounce.sv
source/cmd_regs.sv
source/tx_control.sv
source/led_flash.sv
source/io_block.sv
testbench/tb_clock.sv
testbench/io_block_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module io_block_tb -f compile.f -o sim_io
	@out="$$(./obj_dir/sim_io)"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: testbench/io_block_tb.sv
`timescale 1ns/100ps

module io_block_tb;

  import io_pkg::*;

  localparam string TRACE_FILE = "testbench/io_trace.txt";

  // one trace line
  typedef struct packed {
    logic        tip;
    logic        ring;
    logic        cn8;
    logic        cptt;
    logic [3:0]  strb;
    logic        rqst;
    logic [5:0]  addr;
    logic [31:0] data;
    logic [31:0] hold;
    logic [2:0]  keys;
    logic [5:0]  pa;
    logic [3:0]  led;
    logic        ack;
  } step_t;

  logic     clk;
  logic     rst_i;
  cmd_t     cmd_i;
  logic     cmd_ack_o;
  logic     phone_tip_i;
  logic     phone_ring_i;
  logic     cn8_i;
  logic     cmd_ptt_i;
  logic     rxclipp_i;
  logic     rxclipn_i;
  logic     this_mac_i;
  logic     run_sync_i;
  keys_t    keys_o;
  logic     db1_5_o;
  pa_ctrl_t pa_o;
  logic [3:0] led_o;

  step_t steps[$];
  int    step_idx;
  int    limit_cycles;
  logic  trace_loaded;

  // ------------------------------------------------------------
  // clock, reset and DUT
  // ------------------------------------------------------------

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  io_block #(.DEBOUNCE_CYCLES(8), .FLASH_CYCLES(16)) io_block_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .cmd_i        (cmd_i),
    .cmd_ack_o    (cmd_ack_o),
    .phone_tip_i  (phone_tip_i),
    .phone_ring_i (phone_ring_i),
    .cn8_i        (cn8_i),
    .cmd_ptt_i    (cmd_ptt_i),
    .rxclipp_i    (rxclipp_i),
    .rxclipn_i    (rxclipn_i),
    .this_mac_i   (this_mac_i),
    .run_sync_i   (run_sync_i),
    .keys_o       (keys_o),
    .db1_5_o      (db1_5_o),
    .pa_o         (pa_o),
    .led_o        (led_o)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h (step %0d)",
               name, exp_v, act_v, step_idx);
      $display("Verification failed");
      $fatal(1, "check failed");
    end
  endtask

  // whole trace into memory, hold lengths summed for the watchdog
  task automatic load_trace();
    int    fd;
    int    n_rd;
    int    lineno;
    int    hold_sum;
    string line;
    int    v_tip;
    int    v_ring;
    int    v_cn8;
    int    v_cptt;
    int    v_strb;
    int    v_rqst;
    int    v_addr;
    int    v_data;
    int    v_hold;
    int    v_keys;
    int    v_pa;
    int    v_led;
    int    v_ack;
    step_t st;
    lineno = 0;
    hold_sum = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      abort_run("the trace file could not be opened");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      lineno = lineno + 1;
      // blank lines and comments
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n_rd = $sscanf(line, "%h %h %h %h %h %h %h %h %d %h %h %h %h",
                     v_tip, v_ring, v_cn8, v_cptt, v_strb, v_rqst, v_addr,
                     v_data, v_hold, v_keys, v_pa, v_led, v_ack);
      if (n_rd != 13) begin
        abort_run($sformatf("trace line %0d could not be read", lineno));
      end
      if (v_hold < 1) begin
        abort_run($sformatf("trace line %0d has a hold shorter than one cycle", lineno));
      end
      st.tip  = v_tip[0];
      st.ring = v_ring[0];
      st.cn8  = v_cn8[0];
      st.cptt = v_cptt[0];
      st.strb = v_strb[3:0];
      st.rqst = v_rqst[0];
      st.addr = v_addr[5:0];
      st.data = v_data;
      st.hold = v_hold;
      st.keys = v_keys[2:0];
      st.pa   = v_pa[5:0];
      st.led  = v_led[3:0];
      st.ack  = v_ack[0];
      steps.push_back(st);
      hold_sum = hold_sum + v_hold;
    end
    $fclose(fd);
    if (steps.size() == 0) begin
      abort_run("the trace file holds no steps");
    end
    limit_cycles = hold_sum + 100;
  endtask

  // ------------------------------------------------------------
  // stimulus and checks
  // ------------------------------------------------------------

  initial begin : main
    step_t cur;
    step_idx     = 0;
    limit_cycles = 0;
    trace_loaded = 1'b0;
    // contacts released, everything else idle
    cmd_i        <= '0;
    phone_tip_i  <= 1'b1;
    phone_ring_i <= 1'b1;
    cn8_i        <= 1'b1;
    cmd_ptt_i    <= 1'b0;
    rxclipp_i    <= 1'b0;
    rxclipn_i    <= 1'b0;
    this_mac_i   <= 1'b0;
    run_sync_i   <= 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    @(negedge rst_i);
    for (int s = 0; s < steps.size(); s++) begin
      cur = steps[s];
      step_idx = s;
      @(posedge clk);
      phone_tip_i  <= cur.tip;
      phone_ring_i <= cur.ring;
      cn8_i        <= cur.cn8;
      cmd_ptt_i    <= cur.cptt;
      this_mac_i   <= cur.strb[0];
      run_sync_i   <= cur.strb[1];
      rxclipp_i    <= cur.strb[2];
      rxclipn_i    <= cur.strb[3];
      cmd_i.addr   <= cur.addr;
      cmd_i.data   <= cur.data;
      cmd_i.rqst   <= cur.rqst;
      // request and strobes last one cycle
      @(posedge clk);
      cmd_i.rqst <= 1'b0;
      this_mac_i <= 1'b0;
      run_sync_i <= 1'b0;
      rxclipp_i  <= 1'b0;
      rxclipn_i  <= 1'b0;
      @(negedge clk);
      check("cmd_ack_o", 32'(cur.ack), 32'(cmd_ack_o));
      repeat (cur.hold - 1) @(negedge clk);
      // end of hold, outputs settled
      check("keys_o", 32'(cur.keys), 32'(keys_o));
      check("db1_5_o", 32'(cur.keys[2]), 32'(db1_5_o));
      check("pa_o", 32'(cur.pa), 32'(pa_o));
      check("led_o", 32'(cur.led), 32'(led_o));
    end
    $display("Verification passed");
    $finish;
  end

  // ------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------

  initial begin : watchdog
    wait (trace_loaded);
    repeat (limit_cycles) @(posedge clk);
    abort_run($sformatf("the run did not finish within %0d cycles", limit_cycles));
  end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held high, released on a rising edge
  initial begin
    rst_o <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: source/io_block.sv
`timescale 1ns/100ps

module io_block #(
  parameter int DEBOUNCE_CYCLES = 240000,
  parameter int FLASH_CYCLES    = 10000000
) (
  input  logic             clk,
  input  logic             rst_i,
  // host command bus
  input  io_pkg::cmd_t     cmd_i,
  output logic             cmd_ack_o,
  // raw active-low contacts
  input  logic             phone_tip_i,
  input  logic             phone_ring_i,
  input  logic             cn8_i,
  // host ptt
  input  logic             cmd_ptt_i,
  // status strobes
  input  logic             rxclipp_i,
  input  logic             rxclipn_i,
  input  logic             this_mac_i,
  input  logic             run_sync_i,
  // outputs
  output io_pkg::keys_t    keys_o,
  output logic             db1_5_o,
  output io_pkg::pa_ctrl_t pa_o,
  output logic [3:0]       led_o
);

  import io_pkg::*;

  // stored configuration between decoder and PA control
  tx_cfg_t tx_cfg;

  // ------------------------------------------------------------
  // key conditioning
  // ------------------------------------------------------------

  // cw key on phone tip
  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_cwkey (
    .clk     (clk),
    .rst_i   (rst_i),
    .pb_n_i  (phone_tip_i),
    .clean_o (keys_o.cwkey)
  );

  // ptt on phone ring
  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_ptt (
    .clk     (clk),
    .rst_i   (rst_i),
    .pb_n_i  (phone_ring_i),
    .clean_o (keys_o.ptt)
  );

  // tx inhibit on cn8
  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_txinhibit (
    .clk     (clk),
    .rst_i   (rst_i),
    .pb_n_i  (cn8_i),
    .clean_o (keys_o.txinhibit)
  );

  // debug header shows the cw key
  assign db1_5_o = keys_o.cwkey;

  // ------------------------------------------------------------
  // command register and transmit control
  // ------------------------------------------------------------

  cmd_regs u_cmd_regs (
    .clk   (clk),
    .rst_i (rst_i),
    .cmd_i (cmd_i),
    .cfg_o (tx_cfg),
    .ack_o (cmd_ack_o)
  );

  tx_control u_tx_control (
    .clk       (clk),
    .rst_i     (rst_i),
    .keys_i    (keys_o),
    .cfg_i     (tx_cfg),
    .cmd_ptt_i (cmd_ptt_i),
    .pa_o      (pa_o)
  );

  // ------------------------------------------------------------
  // activity leds, d2 to d5
  // ------------------------------------------------------------

  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) u_led_d2 (
    .clk      (clk),
    .rst_i    (rst_i),
    .strobe_i (this_mac_i),
    .led_o    (led_o[0])
  );

  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) u_led_d3 (
    .clk      (clk),
    .rst_i    (rst_i),
    .strobe_i (run_sync_i),
    .led_o    (led_o[1])
  );

  // rx clip indicators
  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) u_led_d4 (
    .clk      (clk),
    .rst_i    (rst_i),
    .strobe_i (rxclipp_i),
    .led_o    (led_o[2])
  );

  led_flash #(.FLASH_CYCLES(FLASH_CYCLES)) u_led_d5 (
    .clk      (clk),
    .rst_i    (rst_i),
    .strobe_i (rxclipn_i),
    .led_o    (led_o[3])
  );

endmodule

// File: source/led_flash.sv
`timescale 1ns/100ps

module led_flash #(
  parameter int FLASH_CYCLES = 10000000
) (
  input  logic clk,
  input  logic rst_i,
  input  logic strobe_i,
  output logic led_o
);

  import io_pkg::*;

  localparam int CNT_W = $clog2(FLASH_CYCLES + 1);

  flash_state_e     state_q;
  // cycles left before going dark
  logic [CNT_W-1:0] cnt_q;

  // ------------------------------------------------------------
  // stretch FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= DARK;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DARK: begin
          if (strobe_i) begin
            state_q <= LIT;
            cnt_q   <= CNT_W'(FLASH_CYCLES);
          end
        end
        LIT: begin
          if (strobe_i) begin
            // held strobe keeps it lit
            cnt_q <= CNT_W'(FLASH_CYCLES);
          end else if (cnt_q <= CNT_W'(1)) begin
            state_q <= DARK;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q - CNT_W'(1);
          end
        end
        default: begin
          state_q <= DARK;
          cnt_q   <= '0;
        end
      endcase
    end
  end

  // single-bit state, so this is the flop itself
  assign led_o = (state_q == LIT);

endmodule

// File: source/tx_control.sv
`timescale 1ns/100ps

module tx_control (
  input  logic             clk,
  input  logic             rst_i,
  input  io_pkg::keys_t    keys_i,
  input  io_pkg::tx_cfg_t  cfg_i,
  input  logic             cmd_ptt_i,
  output io_pkg::pa_ctrl_t pa_o
);

  import io_pkg::*;

  // ------------------------------------------------------------
  // effective ptt
  // ------------------------------------------------------------

  logic     ptt;
  pa_ctrl_t pa_d;

  // any keying source, overridden by tx inhibit
  assign ptt = (cmd_ptt_i | keys_i.cwkey | keys_i.ptt) & ~keys_i.txinhibit;

  // ------------------------------------------------------------
  // output decode
  // ------------------------------------------------------------

  always_comb begin
    // external T/R follows ptt directly
    pa_d.pa_exttr      = ptt;
    // internal T/R unless disabled without a PA
    pa_d.pa_inttr      = ptt & (cfg_i.pa_enable | ~cfg_i.tr_disable);
    // PA supply and bias only with PA enabled
    pa_d.pwr_envpa     = ptt & cfg_i.pa_enable;
    pa_d.pwr_envbias   = ptt & cfg_i.pa_enable;
    // output stage also powered in vna mode
    pa_d.pwr_envop     = ptt | (cfg_i.vna & ~keys_i.txinhibit);
    // rf switch routes via PA path
    pa_d.rffe_rfsw_sel = cfg_i.pa_enable;
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------

  // all outputs low out of reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pa_o <= '0;
    end else begin
      pa_o <= pa_d;
    end
  end

endmodule

// File: source/cmd_regs.sv
`timescale 1ns/100ps

module cmd_regs (
  input  logic            clk,
  input  logic            rst_i,
  input  io_pkg::cmd_t    cmd_i,
  output io_pkg::tx_cfg_t cfg_o,
  output logic            ack_o
);

  import io_pkg::*;

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------

  // strobe aimed at this block
  logic hit;

  assign hit = cmd_i.rqst && (cmd_i.addr == ADDR_TX_CFG);

  // ------------------------------------------------------------
  // configuration register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_o <= '0;
    end else if (hit) begin
      // vna mode select
      cfg_o.vna        <= cmd_i.data[CFG_VNA_BIT];
      // external PA in use
      cfg_o.pa_enable  <= cmd_i.data[CFG_PA_EN_BIT];
      // keep internal T/R relay idle
      cfg_o.tr_disable <= cmd_i.data[CFG_TR_DIS_BIT];
    end
  end

  // ------------------------------------------------------------
  // acknowledge
  // ------------------------------------------------------------

  // one pulse, the cycle after the request
  // foreign addresses get no answer here
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= hit;
    end
  end

endmodule

// File: source/key_debounce.sv
`timescale 1ns/100ps

module key_debounce #(
  parameter int DEBOUNCE_CYCLES = 240000
) (
  input  logic clk,
  input  logic rst_i,
  input  logic pb_n_i,
  output logic clean_o
);

  import io_pkg::*;

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  // ------------------------------------------------------------
  // input synchronizer
  // ------------------------------------------------------------

  // two flops, released contact reads high
  logic [1:0] sync_q;
  // active-high view of the synchronized contact
  logic       level;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], pb_n_i};
    end
  end

  assign level = ~sync_q[1];

  // ------------------------------------------------------------
  // settle counter
  // ------------------------------------------------------------

  deb_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= STABLE;
      cnt_q   <= '0;
      clean_o <= 1'b0;
    end else begin
      case (state_q)
        STABLE: begin
          // first cycle of a new level counts as one
          if (level != clean_o) begin
            state_q <= SETTLING;
            cnt_q   <= CNT_W'(1);
          end
        end
        SETTLING: begin
          if (level == clean_o) begin
            // bounced back, start over
            state_q <= STABLE;
            cnt_q   <= '0;
          end else if (cnt_q >= CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            clean_o <= level;
            state_q <= STABLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + CNT_W'(1);
          end
        end
        default: begin
          state_q <= STABLE;
          cnt_q   <= '0;
        end
      endcase
    end
  end

endmodule

// File: source/io_pkg.sv
package io_pkg;

  // ------------------------------------------------------------
  // host command bus
  // ------------------------------------------------------------

  // command addresses seen on the shared host bus
  typedef enum logic [5:0] {
    ADDR_TX_FREQ = 6'h01,  // owned by another block
    ADDR_TX_CFG  = 6'h09   // transmit configuration
  } cmd_addr_e;

  // one host command, rqst is a single-cycle strobe
  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        rqst;
  } cmd_t;

  // bit positions inside the ADDR_TX_CFG data word
  localparam int CFG_VNA_BIT    = 23;
  localparam int CFG_PA_EN_BIT  = 19;
  localparam int CFG_TR_DIS_BIT = 18;

  // stored transmit configuration
  typedef struct packed {
    logic vna;
    logic pa_enable;
    logic tr_disable;
  } tx_cfg_t;

  // ------------------------------------------------------------
  // front panel keys and PA control
  // ------------------------------------------------------------

  // debounced keys, all active high
  typedef struct packed {
    logic cwkey;
    logic ptt;
    logic txinhibit;
  } keys_t;

  // PA, T/R and power enables for the later board set
  typedef struct packed {
    logic pa_inttr;
    logic pa_exttr;
    logic pwr_envpa;
    logic pwr_envop;
    logic pwr_envbias;
    logic rffe_rfsw_sel;
  } pa_ctrl_t;

  // debouncer FSM
  typedef enum logic {
    STABLE,
    SETTLING
  } deb_state_e;

  // led stretcher FSM
  typedef enum logic {
    DARK,
    LIT
  } flash_state_e;

endpackage
